// ==== bitGen_settings.svh ====
`ifndef BITGEN_SETTINGS_SVH
`define BITGEN_SETTINGS_SVH

`define COUNT_WIDTH     10  // hCount/vCount width
`define GRID_COLS       5
`define GRID_ROWS       6
`define CELL_COUNT      30  // Cols times rows
`define CELL_ADDR_WIDTH 5
`define CELL_BITS       6   // 64 pixel cells

// Grid origin on screen
`define GRID_LEFT       128
`define GRID_TOP        64

`define SPRITE_SHIFT    3   // Bitmap scaled up by 8
`define GLYPH_WIDTH     5

`endif

// ==== glyphPkg.sv ====
`default_nettype none

`include "bitGen_settings.svh"

package glyphPkg;

    typedef logic [`COUNT_WIDTH-1:0] pixelCount_t;      // Screen coordinate
    typedef logic [`CELL_ADDR_WIDTH-1:0] cellAddr_t;    // Row plus six times column

    // Codes not listed here display as blank
    typedef enum logic [`GLYPH_WIDTH-1:0] {
        glyphBlank = 0,
        glyphShip  = 1,
        glyphAlien = 2
    } glyphCode_t;

    typedef enum logic [2:0] {
        colorBlack = 3'd0,
        colorBlue  = 3'd1,
        colorRed   = 3'd4,
        colorWhite = 3'd7
    } rgbColor_t;

endpackage

`default_nettype wire

// ==== cellLocator.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bitGen_settings.svh"

module cellLocator import glyphPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        bright,
    input  pixelCount_t hCount,
    input  pixelCount_t vCount,
    output logic        inCellQ,
    output cellAddr_t   cellIdxQ
);

    localparam pixelCount_t gridLeft   = pixelCount_t'(`GRID_LEFT);
    localparam pixelCount_t gridTop    = pixelCount_t'(`GRID_TOP);
    localparam pixelCount_t gridRight  = pixelCount_t'(`GRID_LEFT + (`GRID_COLS << `CELL_BITS));
    localparam pixelCount_t gridBottom = pixelCount_t'(`GRID_TOP + (`GRID_ROWS << `CELL_BITS));

    pixelCount_t xOff;
    pixelCount_t yOff;
    logic [`COUNT_WIDTH-`CELL_BITS-1:0] colIdx;
    logic [`COUNT_WIDTH-`CELL_BITS-1:0] rowIdx;
    logic inGrid;
    logic offEdge;
    logic inCell;
    cellAddr_t cellIdx;

    assign xOff = hCount - gridLeft;
    assign yOff = vCount - gridTop;

    assign colIdx = xOff[`COUNT_WIDTH-1:`CELL_BITS];
    assign rowIdx = yOff[`COUNT_WIDTH-1:`CELL_BITS];

    assign inGrid = (hCount >= gridLeft) && (hCount < gridRight) &&
                    (vCount >= gridTop) && (vCount < gridBottom);

    // A pixel on a cell boundary line belongs to no cell
    assign offEdge = (xOff[`CELL_BITS-1:0] != '0) && (yOff[`CELL_BITS-1:0] != '0);

    assign inCell = bright && inGrid && offEdge;

    assign cellIdx = cellAddr_t'(rowIdx) + cellAddr_t'(colIdx) * cellAddr_t'(`GRID_ROWS);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            inCellQ  <= 1'b0;
            cellIdxQ <= '0;
        end else begin
            inCellQ  <= inCell;
            cellIdxQ <= cellIdx;    // Only meaningful with inCell
        end
    end

endmodule

`default_nettype wire

// ==== spriteRom.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bitGen_settings.svh"

module spriteRom import glyphPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  pixelCount_t hCount,
    input  pixelCount_t vCount,
    output rgbColor_t   shipColorQ,
    output rgbColor_t   alienColorQ
);

    localparam int SubBits = `CELL_BITS - `SPRITE_SHIFT;

    // Bitmap color shorthands
    localparam rgbColor_t blk = colorBlack;
    localparam rgbColor_t wht = colorWhite;
    localparam rgbColor_t blu = colorBlue;
    localparam rgbColor_t red = colorRed;

    logic [SubBits-1:0] subRow;
    logic [SubBits-1:0] subCol;

    // Grid origin is cell aligned, so raw count bits give the sub-pixel
    assign subRow = vCount[`CELL_BITS-1:`SPRITE_SHIFT];
    assign subCol = hCount[`CELL_BITS-1:`SPRITE_SHIFT];

    function automatic rgbColor_t shipPixel(
        input logic [SubBits-1:0] row,
        input logic [SubBits-1:0] col
    );
        rgbColor_t line [8];
        case (row)
            3'd0: line = '{blk, blk, blk, wht, wht, blk, blk, blk};    // Nose
            3'd1: line = '{blk, blk, wht, blu, blu, wht, blk, blk};
            3'd2: line = '{blk, blk, wht, blu, blu, wht, blk, blk};
            3'd3: line = '{wht, wht, blu, blu, blu, blu, wht, wht};    // Wings
            3'd4: line = '{wht, wht, blu, blu, blu, blu, wht, wht};
            3'd5: line = '{blk, blk, wht, blu, blu, wht, blk, blk};
            3'd6: line = '{blk, blk, red, blk, blk, red, blk, blk};    // Exhaust
            3'd7: line = '{blk, blk, red, blk, blk, red, blk, blk};
            default: line = '{default: blk};
        endcase
        return line[col];
    endfunction

    function automatic rgbColor_t alienPixel(
        input logic [SubBits-1:0] row,
        input logic [SubBits-1:0] col
    );
        rgbColor_t line [8];
        case (row)
            3'd0: line = '{blu, blk, blk, blk, blk, blk, blk, blu};    // Antenna tips
            3'd1: line = '{blk, blu, blk, blk, blk, blk, blu, blk};
            3'd2: line = '{blk, blu, blu, blk, blk, blu, blu, blk};
            3'd3: line = '{blk, blk, blu, blu, blu, blu, blk, blk};
            3'd4: line = '{blk, blk, blk, blu, blu, blk, blk, blk};    // Stem
            3'd5: line = '{blk, blk, blk, blu, blu, blk, blk, blk};
            3'd6: line = '{blk, blk, blk, blu, blu, blk, blk, blk};
            3'd7: line = '{blk, blk, blk, blu, blu, blk, blk, blk};
            default: line = '{default: blk};
        endcase
        return line[col];
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shipColorQ  <= colorBlack;
            alienColorQ <= colorBlack;
        end else begin
            shipColorQ  <= shipPixel(subRow, subCol);
            alienColorQ <= alienPixel(subRow, subCol);
        end
    end

endmodule

`default_nettype wire

// ==== pixelMixer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bitGen_settings.svh"

module pixelMixer import glyphPkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       glyphWe,
    input  cellAddr_t  glyphAddr,
    input  glyphCode_t glyphCode,
    input  logic       inCell,
    input  cellAddr_t  cellIdx,
    input  rgbColor_t  shipColor,
    input  rgbColor_t  alienColor,
    output rgbColor_t  rgb
);

    localparam cellAddr_t cellLimit = cellAddr_t'(`CELL_COUNT);

    glyphCode_t cells [`CELL_COUNT];
    glyphCode_t cellCode;
    rgbColor_t  nextColor;

    // One glyph code per grid cell
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `CELL_COUNT; i++) begin
                cells[i] <= glyphBlank;
            end
        end else if (glyphWe && (glyphAddr < cellLimit)) begin
            cells[glyphAddr] <= glyphCode;  // Out of range writes dropped
        end
    end

    always_comb begin
        cellCode = glyphBlank;
        if (cellIdx < cellLimit) begin
            cellCode = cells[cellIdx];
        end
    end

    always_comb begin
        nextColor = colorBlack;
        if (inCell) begin
            case (cellCode)
                glyphShip:  nextColor = shipColor;
                glyphAlien: nextColor = alienColor;
                default:    nextColor = colorBlack;    // Unknown codes stay dark
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rgb <= colorBlack;
        end else begin
            rgb <= nextColor;
        end
    end

endmodule

`default_nettype wire

// ==== bitGen.sv ====
`timescale 1ns/100ps
`default_nettype none

module bitGen import glyphPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        bright,
    input  pixelCount_t hCount,
    input  pixelCount_t vCount,
    input  logic        glyphWe,
    input  cellAddr_t   glyphAddr,
    input  glyphCode_t  glyphCode,
    output rgbColor_t   rgb
);

    logic      inCell;
    cellAddr_t cellIdx;
    rgbColor_t shipColor;
    rgbColor_t alienColor;

    // Geometry and bitmaps side by side in stage 1
    cellLocator i_cellLocator (
        .clk      (clk),
        .rstN     (rstN),
        .bright   (bright),
        .hCount   (hCount),
        .vCount   (vCount),
        .inCellQ  (inCell),
        .cellIdxQ (cellIdx)
    );

    spriteRom i_spriteRom (
        .clk         (clk),
        .rstN        (rstN),
        .hCount      (hCount),
        .vCount      (vCount),
        .shipColorQ  (shipColor),
        .alienColorQ (alienColor)
    );

    // Glyph lookup and output register in stage 2
    pixelMixer i_pixelMixer (
        .clk        (clk),
        .rstN       (rstN),
        .glyphWe    (glyphWe),
        .glyphAddr  (glyphAddr),
        .glyphCode  (glyphCode),
        .inCell     (inCell),
        .cellIdx    (cellIdx),
        .shipColor  (shipColor),
        .alienColor (alienColor),
        .rgb        (rgb)
    );

endmodule

`default_nettype wire

// ==== bitGenTb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "bitGen_settings.svh"

module bitGenTb import glyphPkg::*; ();

    localparam int cellSize     = 1 << `CELL_BITS;
    localparam int scale        = 1 << `SPRITE_SHIFT;
    localparam int gridRight    = `GRID_LEFT + `GRID_COLS * cellSize;
    localparam int gridBottom   = `GRID_TOP + `GRID_ROWS * cellSize;
    localparam int resetTimeout = 20;
    localparam int flushTimeout = 10;

    logic        clk;
    logic        rstN;
    logic        bright;
    pixelCount_t hCount;
    pixelCount_t vCount;
    logic        glyphWe;
    cellAddr_t   glyphAddr;
    glyphCode_t  glyphCode;
    rgbColor_t   rgb;

    glyphCode_t shadow [`CELL_COUNT];    // Expected cell store contents

    // Expected value travelling alongside the DUT pipeline
    logic      trackNow;
    rgbColor_t expNow;
    int        hNow;
    int        vNow;
    logic      stgValid [2];
    rgbColor_t stgExp [2];
    int        stgH [2];
    int        stgV [2];

    int seed       = 68;
    int errorCount = 0;
    int checkCount = 0;
    int testCount  = 0;

    bitGen i_dut (
        .clk       (clk),
        .rstN      (rstN),
        .bright    (bright),
        .hCount    (hCount),
        .vCount    (vCount),
        .glyphWe   (glyphWe),
        .glyphAddr (glyphAddr),
        .glyphCode (glyphCode),
        .rgb       (rgb)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;    // 40 ns period

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stgValid[0] <= 1'b0;
            stgValid[1] <= 1'b0;
        end else begin
            stgValid[0] <= trackNow;
            stgExp[0]   <= expNow;
            stgH[0]     <= hNow;
            stgV[0]     <= vNow;
            stgValid[1] <= stgValid[0];
            stgExp[1]   <= stgExp[0];
            stgH[1]     <= stgH[0];
            stgV[1]     <= stgV[0];
        end
    end

    // rgb is stable mid cycle
    always @(negedge clk) begin
        if (stgValid[1]) begin
            checkColor(stgExp[1], rgb, $sformatf("pixel h=%0d v=%0d", stgH[1], stgV[1]));
        end
    end

    task automatic checkColor(input rgbColor_t expected, input rgbColor_t actual,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED t=%0t %s: expected %s (%0d), got %s (%0d)", $time, what,
                     expected.name(), expected, actual.name(), actual);
        end
    endtask

    task automatic failTimeout(input string what);
        $display("Timeout: %s", what);
        $display("sim failed");
        $finish;
    endtask

    task automatic finishTest(input string name, input int errorsAtStart);
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errorCount - errorsAtStart);
        end
    endtask

    function automatic string bitmapRow(input glyphCode_t code, input int row);
        string line;
        line = "KKKKKKKK";
        if (code == glyphShip) begin
            case (row)
                0:       line = "KKKWWKKK";
                1, 2, 5: line = "KKWBBWKK";
                3, 4:    line = "WWBBBBWW";
                default: line = "KKRKKRKK";
            endcase
        end else if (code == glyphAlien) begin
            case (row)
                0:       line = "BKKKKKKB";
                1:       line = "KBKKKKBK";
                2:       line = "KBBKKBBK";
                3:       line = "KKBBBBKK";
                default: line = "KKKBBKKK";
            endcase
        end
        return line;
    endfunction

    function automatic rgbColor_t charColor(input byte c);
        rgbColor_t color;
        case (c)
            "W":     color = colorWhite;
            "B":     color = colorBlue;
            "R":     color = colorRed;
            default: color = colorBlack;
        endcase
        return color;
    endfunction

    function automatic rgbColor_t expectedColor(input logic b, input int h, input int v);
        int         x;
        int         y;
        glyphCode_t code;
        string      line;
        x = h - `GRID_LEFT;
        y = v - `GRID_TOP;
        if (!b || h < `GRID_LEFT || h >= gridRight || v < `GRID_TOP || v >= gridBottom) begin
            return colorBlack;
        end
        if ((x % cellSize) == 0 || (y % cellSize) == 0) begin
            return colorBlack;    // Boundary lines are exclusive
        end
        code = shadow[(y / cellSize) + `GRID_ROWS * (x / cellSize)];
        if (code != glyphShip && code != glyphAlien) begin
            return colorBlack;
        end
        line = bitmapRow(code, (y % cellSize) / scale);
        return charColor(line.getc((x % cellSize) / scale));
    endfunction

    task automatic applyPixel(input logic b, input int h, input int v,
                              input rgbColor_t expected);
        @(posedge clk);
        bright   <= b;
        hCount   <= pixelCount_t'(h);
        vCount   <= pixelCount_t'(v);
        trackNow <= 1'b1;
        expNow   <= expected;
        hNow     <= h;
        vNow     <= v;
    endtask

    task automatic drivePixel(input logic b, input int h, input int v);
        applyPixel(b, h, v, expectedColor(b, h, v));
    endtask

    // Stop tracking and wait until the last pixel has been checked
    task automatic flushPipe();
        int cycles;
        @(posedge clk);
        trackNow <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((stgValid[0] || stgValid[1]) && cycles < flushTimeout);
        if (stgValid[0] || stgValid[1]) begin
            failTimeout("pixel pipeline did not drain");
        end
    endtask

    task automatic writeCell(input int addr, input glyphCode_t code);
        @(posedge clk);
        trackNow  <= 1'b0;
        glyphWe   <= 1'b1;
        glyphAddr <= cellAddr_t'(addr);
        glyphCode <= code;
        @(posedge clk);
        glyphWe <= 1'b0;
        if (addr < `CELL_COUNT) begin
            shadow[addr] = code;    // Higher addresses are ignored by the DUT
        end
    endtask

    // One pixel per sub-pixel square at a varying spot inside it
    task automatic sweepCell(input int row, input int col, input logic b);
        int x0;
        int y0;
        int h;
        int v;
        x0 = `GRID_LEFT + col * cellSize;
        y0 = `GRID_TOP + row * cellSize;
        for (int sr = 0; sr < 8; sr++) begin
            for (int sc = 0; sc < 8; sc++) begin
                h = x0 + sc * scale + 1 + (sr + sc) % (scale - 1);
                v = y0 + sr * scale + 1 + (sr * 3 + sc) % (scale - 1);
                drivePixel(b, h, v);
            end
        end
    endtask

    task automatic testReset();
        int startErrors;
        int cycles;
        startErrors = errorCount;
        cycles = 0;
        while (rstN !== 1'b1 && cycles < resetTimeout) begin
            @(negedge clk);
            cycles++;
        end
        if (rstN !== 1'b1) begin
            failTimeout("reset was never released");
        end
        checkColor(colorBlack, rgb, "rgb after reset");
        for (int col = 0; col < `GRID_COLS; col++) begin
            for (int row = 0; row < `GRID_ROWS; row++) begin
                applyPixel(1'b1, `GRID_LEFT + col * cellSize + cellSize / 2,
                           `GRID_TOP + row * cellSize + cellSize / 2, colorBlack);
            end
        end
        flushPipe();
        finishTest("reset", startErrors);
    endtask

    task automatic testShip();
        int startErrors;
        startErrors = errorCount;
        writeCell(7, glyphShip);    // Row 1, column 1
        sweepCell(1, 1, 1'b1);
        flushPipe();
        finishTest("ship", startErrors);
    endtask

    task automatic testAlien();
        int startErrors;
        startErrors = errorCount;
        writeCell(29, glyphAlien);    // Row 5, column 4
        sweepCell(5, 4, 1'b1);
        flushPipe();
        writeCell(29, glyphBlank);
        sweepCell(5, 4, 1'b1);
        flushPipe();
        finishTest("alien", startErrors);
    endtask

    task automatic testBoundaries();
        int startErrors;
        int x0;
        int y0;
        startErrors = errorCount;
        x0 = `GRID_LEFT + cellSize;
        y0 = `GRID_TOP + cellSize;
        // Every cell lit so a misplaced pixel would show
        for (int i = 0; i < `CELL_COUNT; i++) begin
            writeCell(i, glyphShip);
        end
        applyPixel(1'b0, x0 + 28, y0 + 28, colorBlack);    // Blue ship pixel with bright low
        applyPixel(1'b0, x0 + 3, y0 + 30, colorBlack);
        applyPixel(1'b0, x0 + 50, y0 + 36, colorBlack);
        applyPixel(1'b1, x0, y0 + 28, colorBlack);
        applyPixel(1'b1, x0 + 28, y0, colorBlack);
        applyPixel(1'b1, x0, y0, colorBlack);
        applyPixel(1'b1, x0 + cellSize, y0 + 28, colorBlack);
        applyPixel(1'b1, x0 + 28, y0 + cellSize, colorBlack);
        applyPixel(1'b1, `GRID_LEFT - 1, y0 + 28, colorBlack);
        applyPixel(1'b1, x0 + 28, `GRID_TOP - 1, colorBlack);
        applyPixel(1'b1, gridRight, y0 + 28, colorBlack);
        applyPixel(1'b1, gridRight + 28, y0 + cellSize + 28, colorBlack);
        applyPixel(1'b1, x0 + 28, gridBottom, colorBlack);
        applyPixel(1'b1, x0 + 28, gridBottom + 28, colorBlack);
        applyPixel(1'b1, 0, 0, colorBlack);
        applyPixel(1'b1, 1023, 1023, colorBlack);
        drivePixel(1'b1, x0 + 28, y0 + 28);    // Same spot lit again
        flushPipe();
        finishTest("boundaries", startErrors);
    endtask

    task automatic testRandomFill();
        int                       startErrors;
        int                       rnd;
        int                       h;
        int                       v;
        logic                     b;
        logic [`GLYPH_WIDTH-1:0]  raw;
        startErrors = errorCount;
        for (int i = 0; i < `CELL_COUNT; i++) begin
            rnd = int'($unsigned($random(seed)) % 4);
            raw = rnd[`GLYPH_WIDTH-1:0];
            writeCell(i, glyphCode_t'(raw));
        end
        writeCell(31, glyphShip);    // Out of range
        for (int n = 0; n < 300; n++) begin
            b = (($random(seed) & 7) != 0);
            h = 96 + int'($unsigned($random(seed)) % 400);
            v = 40 + int'($unsigned($random(seed)) % 440);
            drivePixel(b, h, v);
        end
        flushPipe();
        finishTest("random fill", startErrors);
    endtask

    initial begin
        rstN      = 1'b0;
        bright    = 1'b0;
        hCount    = '0;
        vCount    = '0;
        glyphWe   = 1'b0;
        glyphAddr = '0;
        glyphCode = glyphBlank;
        trackNow  = 1'b0;
        expNow    = colorBlack;
        hNow      = 0;
        vNow      = 0;
        for (int i = 0; i < `CELL_COUNT; i++) begin
            shadow[i] = glyphBlank;
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        testReset();
        testShip();
        testAlien();
        testBoundaries();
        testRandomFill();

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
glyphPkg.sv
cellLocator.sv
spriteRom.sv
pixelMixer.sv
bitGen.sv
bitGenTb.sv

// ==== runSim.sh ====
#!/bin/bash
# Build and run the bitGen testbench with Verilator, then scan the log

rm -rf obj_dir build.log sim.log

verilator --binary --timing --top-module bitGenTb -f verilog.f -o bitGenSim > build.log 2>&1 \
    && ./obj_dir/bitGenSim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }

cat sim.log

grep -q "sim failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "sim passed" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation PASSED"
exit 0
